// ==== source/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;

    // Major opcode field, instr[6:0]
    typedef logic [6:0] opcode_t;

    localparam opcode_t op_load   = 7'b00_000_11;
    localparam opcode_t op_op_imm = 7'b00_100_11;
    localparam opcode_t op_auipc  = 7'b00_101_11;
    localparam opcode_t op_store  = 7'b01_000_11;
    localparam opcode_t op_op     = 7'b01_100_11;
    localparam opcode_t op_lui    = 7'b01_101_11;
    localparam opcode_t op_branch = 7'b11_000_11;
    localparam opcode_t op_jalr   = 7'b11_001_11;
    localparam opcode_t op_jal    = 7'b11_011_11;
    localparam opcode_t op_system = 7'b11_100_11;

    // Instruction formats
    typedef enum logic [2:0]
    {
        r_type = 3'd0,
        i_type = 3'd1,
        s_type = 3'd2,
        b_type = 3'd3,
        u_type = 3'd4,
        j_type = 3'd5
    } instr_type_t;

    // Branch conditions in funct3
    typedef enum logic [2:0]
    {
        f3_beq  = 3'b000,
        f3_bne  = 3'b001,
        f3_blt  = 3'b100,
        f3_bge  = 3'b101,
        f3_bltu = 3'b110,
        f3_bgeu = 3'b111
    } branch_funct3_t;

    typedef logic [4:0] reg_addr_t;

endpackage

// ==== source/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder
(
    input  logic [31:0]              instr,

    output rv_pkg::opcode_t          opcode,
    output logic [2:0]               funct3,
    output rv_pkg::instr_type_t      instruction_type,
    output rv_pkg::reg_addr_t        rs1_addr,
    output rv_pkg::reg_addr_t        rs2_addr,
    output rv_pkg::reg_addr_t        rd_addr,
    output logic [rv_pkg::xlen-1:0]  imm
);

    import rv_pkg::*;

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    // Fixed field positions, valid for every format
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];

    // Format from the opcode
    always_comb
    begin
        case (opcode)
            op_op:
                instruction_type = r_type;
            op_load, op_op_imm, op_jalr, op_system:
                instruction_type = i_type;
            op_store:
                instruction_type = s_type;
            op_branch:
                instruction_type = b_type;
            op_lui, op_auipc:
                instruction_type = u_type;
            op_jal:
                instruction_type = j_type;
            default:
                instruction_type = r_type;     // Unknown opcode
        endcase
    end

    // Immediates, sign taken from instr[31]
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        case (instruction_type)
            i_type:
                imm = imm_i;
            s_type:
                imm = imm_s;
            b_type:
                imm = imm_b;
            u_type:
                imm = imm_u;
            j_type:
                imm = imm_j;
            default:
                imm = '0;      // R-type has no immediate
        endcase
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  rv_pkg::reg_addr_t        rs1_addr,
    input  rv_pkg::reg_addr_t        rs2_addr,

    input  logic                     wr_en,
    input  rv_pkg::reg_addr_t        wr_addr,
    input  logic [rv_pkg::xlen-1:0]  wr_data,

    input  logic                     link_en,
    input  rv_pkg::reg_addr_t        link_addr,
    input  logic [rv_pkg::xlen-1:0]  link_data,

    output logic [rv_pkg::xlen-1:0]  rs1_data,
    output logic [rv_pkg::xlen-1:0]  rs2_data
);

    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    // x0 is never written, so it keeps its reset value
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else
        begin
            for (int i = 1; i < 32; i++)
            begin
                if (link_en && link_addr == reg_addr_t'(i))
                    regs[i] <= link_data;      // Link beats external write
                else if (wr_en && wr_addr == reg_addr_t'(i))
                    regs[i] <= wr_data;
            end
        end
    end

    // Reads see the value before any write at the coming edge
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== source/jump_branch_unit.sv ====
`timescale 1ns/1ps

module jump_branch_unit
(
    input  rv_pkg::opcode_t          opcode,
    input  logic [2:0]               funct3,
    input  rv_pkg::instr_type_t      instruction_type,

    input  logic [rv_pkg::xlen-1:0]  rs1,
    input  logic [rv_pkg::xlen-1:0]  rs2,

    output logic                     jump_branch_enable    // To fetch_unit
);

    import rv_pkg::*;

    logic branch_enable;
    logic jump_enable;

    always_comb
    begin
        branch_enable = 1'b0;
        if (instruction_type == b_type)
        begin
            case (branch_funct3_t'(funct3))
                f3_beq:
                    branch_enable = (rs1 == rs2);
                f3_bne:
                    branch_enable = (rs1 != rs2);
                f3_blt:
                    branch_enable = ($signed(rs1) < $signed(rs2));
                f3_bge:
                    branch_enable = ($signed(rs1) >= $signed(rs2));
                f3_bltu:
                    branch_enable = (rs1 < rs2);
                f3_bgeu:
                    branch_enable = (rs1 >= rs2);
                default:
                    branch_enable = 1'b0;  // 010 and 011 are reserved
            endcase
        end
    end

    // Jumps are unconditional
    always_comb
    begin
        if (opcode == op_jal || opcode == op_jalr)
            jump_enable = 1'b1;
        else
            jump_enable = 1'b0;
    end

    assign jump_branch_enable = jump_enable || branch_enable;

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
#(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
)
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     instr_valid,
    input  rv_pkg::opcode_t          opcode,
    input  logic [rv_pkg::xlen-1:0]  imm,
    input  logic [rv_pkg::xlen-1:0]  rs1_data,
    input  logic                     jump_branch_enable,

    output logic [rv_pkg::xlen-1:0]  pc,
    output logic                     redirect,
    output logic [rv_pkg::xlen-1:0]  redirect_target,

    output logic                     link_en,
    output logic [rv_pkg::xlen-1:0]  link_data
);

    import rv_pkg::*;

    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] jalr_sum;
    logic [xlen-1:0] target_pc;
    logic [xlen-1:0] next_pc;
    logic            taken;

    assign seq_pc   = pc + xlen'(4);
    assign jalr_sum = rs1_data + imm;

    // JALR clears bit 0 of the sum
    assign target_pc = (opcode == op_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm;

    assign taken   = instr_valid && jump_branch_enable;
    assign next_pc = jump_branch_enable ? target_pc : seq_pc;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc       <= reset_pc;
            redirect <= 1'b0;
        end
        else
        begin
            if (instr_valid)
                pc <= next_pc;
            redirect <= taken;     // One cycle pulse
        end
    end

    always_ff @(posedge clk)
    begin
        if (taken)
            redirect_target <= target_pc;
    end

    // Return address, written at the same edge as the PC update
    assign link_en   = instr_valid && (opcode == op_jal || opcode == op_jalr);
    assign link_data = seq_pc;

endmodule

// ==== source/branch_core.sv ====
`timescale 1ns/1ps

module branch_core
#(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
)
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     instr_valid,
    input  logic [31:0]              instr,

    // External register loading
    input  logic                     reg_wr_en,
    input  rv_pkg::reg_addr_t        reg_wr_addr,
    input  logic [rv_pkg::xlen-1:0]  reg_wr_data,

    output logic [rv_pkg::xlen-1:0]  pc,
    output logic                     redirect,
    output logic [rv_pkg::xlen-1:0]  redirect_target
);

    import rv_pkg::*;

    opcode_t         opcode;
    logic [2:0]      funct3;
    instr_type_t     instruction_type;
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    reg_addr_t       rd_addr;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            jump_branch_enable;
    logic            link_en;
    logic [xlen-1:0] link_data;

    instruction_decoder instruction_decoder_inst
    (
        .instr            (instr),
        .opcode           (opcode),
        .funct3           (funct3),
        .instruction_type (instruction_type),
        .rs1_addr         (rs1_addr),
        .rs2_addr         (rs2_addr),
        .rd_addr          (rd_addr),
        .imm              (imm)
    );

    register_file register_file_inst
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .wr_en     (reg_wr_en),
        .wr_addr   (reg_wr_addr),
        .wr_data   (reg_wr_data),
        .link_en   (link_en),
        .link_addr (rd_addr),
        .link_data (link_data),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    jump_branch_unit jump_branch_unit_inst
    (
        .opcode             (opcode),
        .funct3             (funct3),
        .instruction_type   (instruction_type),
        .rs1                (rs1_data),
        .rs2                (rs2_data),
        .jump_branch_enable (jump_branch_enable)
    );

    fetch_unit
    #(
        .reset_pc (reset_pc)
    )
    fetch_unit_inst
    (
        .clk                (clk),
        .rst_n              (rst_n),
        .instr_valid        (instr_valid),
        .opcode             (opcode),
        .imm                (imm),
        .rs1_data           (rs1_data),
        .jump_branch_enable (jump_branch_enable),
        .pc                 (pc),
        .redirect           (redirect),
        .redirect_target    (redirect_target),
        .link_en            (link_en),
        .link_data          (link_data)
    );

endmodule

// ==== sim/tb_branch_core.sv ====
`timescale 1ns/1ps

module tb_branch_core;

    localparam logic [31:0] reset_pc = 32'h0000_1000;
    localparam int rec_cols = 7;       // test, kind, instr, wr_addr, wr_data, exp_pc, exp_redirect
    localparam int max_recs = 128;
    localparam int reset_cycles = 16;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        reg_wr_en;
    logic [4:0]  reg_wr_addr;
    logic [31:0] reg_wr_data;
    logic [31:0] pc;
    logic        redirect;
    logic [31:0] redirect_target;

    logic [31:0] patterns [rec_cols*max_recs];

    int num_recs;
    int cycle_limit = 0;
    int cycle_count = 0;
    int error_count = 0;
    int check_count = 0;
    int test_errors = 0;
    int test_checks = 0;
    int tests_done = 0;

    branch_core
    #(
        .reset_pc (reset_pc)
    )
    branch_core_inst
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .reg_wr_en       (reg_wr_en),
        .reg_wr_addr     (reg_wr_addr),
        .reg_wr_data     (reg_wr_data),
        .pc              (pc),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    initial
        clk = 1'b0;

    always #4 clk = ~clk;

    // Run limit, set once the pattern count is known
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("Simulation timed out after %0d cycles", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] record_field(input int rec, input int col);
        return patterns[rec*rec_cols + col];
    endfunction

    // Records end at the first kind outside 0..3
    function automatic int count_records();
        int n;
        n = 0;
        while (n < max_recs && patterns[n*rec_cols + 1] <= 32'd3)
            n++;
        return n;
    endfunction

    function automatic string test_name(input logic [31:0] n);
        case (n)
            1: return "reset and sequential";
            2: return "branch conditions";
            3: return "jal link";
            4: return "jalr and x0";
            5: return "idle and back-to-back";
            6: return "write priority";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        test_checks++;
        assert (actual === expected)
        else
        begin
            $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic apply_record(input int rec);
        logic [31:0] kind;
        logic [31:0] addr;
        kind = record_field(rec, 1);
        addr = record_field(rec, 3);
        instr_valid = kind[1];
        reg_wr_en   = kind[0];
        instr       = record_field(rec, 2);
        reg_wr_addr = addr[4:0];
        reg_wr_data = record_field(rec, 4);
    endtask

    task automatic check_record(input int rec);
        logic [31:0] exp_pc;
        logic [31:0] exp_red;
        exp_pc  = record_field(rec, 5);
        exp_red = record_field(rec, 6);
        check_value("pc", exp_pc, pc);
        check_value("redirect", {31'b0, exp_red[0]}, {31'b0, redirect});
        if (exp_red[0])
            check_value("redirect_target", exp_pc, redirect_target);  // Target is the new PC
    endtask

    task automatic close_test(input logic [31:0] n);
        tests_done++;
        $display("Test %0d (%s) done: %0d checks, %0d errors",
                 n, test_name(n), test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    initial
    begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        reg_wr_en   = 1'b0;
        reg_wr_addr = '0;
        reg_wr_data = '0;

        for (int i = 0; i < rec_cols*max_recs; i++)
            patterns[i] = 32'hbad0_0000 | 32'(i);
        $readmemh("sim/branch_patterns.mem", patterns);
        num_recs = count_records();
        cycle_limit = num_recs + reset_cycles + 50;

        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("pc", reset_pc, pc);
        check_value("redirect", 32'd0, {31'b0, redirect});

        if (num_recs == 0)
        begin
            $display("No stimulus records were loaded from the pattern file");
            error_count++;
        end

        for (int r = 0; r < num_recs; r++)
        begin
            apply_record(r);
            @(posedge clk);
            #1;
            check_record(r);
            if (r == num_recs - 1 || record_field(r + 1, 0) != record_field(r, 0))
                close_test(record_field(r, 0));
        end

        $display("%0d tests, %0d checks, %0d errors", tests_done, check_count, error_count);
        if (error_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== sim/branch_patterns.mem ====
// Columns: test kind instr wr_addr wr_data exp_pc exp_redirect
// Kind: 0 idle, 1 register write, 2 instruction, 3 instruction plus register write, f end
1 0 00000000 00 00000000 00001000 0 // idle after reset
1 2 003100b3 00 00000000 00001004 0 // add x1,x2,x3
1 2 00100293 00 00000000 00001008 0 // addi x5,x0,1
1 2 0000a303 00 00000000 0000100c 0 // lw x6,0(x1)
1 2 0020a223 00 00000000 00001010 0 // sw x2,4(x1)
1 2 123453b7 00 00000000 00001014 0 // lui x7,0x12345
1 0 00000000 00 00000000 00001014 0
2 1 00000000 01 00000005 00001014 0
2 1 00000000 02 00000005 00001014 0
2 1 00000000 03 ffffffff 00001014 0
2 1 00000000 04 00000007 00001014 0
2 1 00000000 05 80000000 00001014 0
2 2 00208863 00 00000000 00001024 1 // beq x1,x2,+16
2 2 00408863 00 00000000 00001028 0 // beq x1,x4,+16
2 2 fe409ce3 00 00000000 00001020 1 // bne x1,x4,-8
2 2 fe209ce3 00 00000000 00001024 0 // bne x1,x2,-8
2 2 0011c863 00 00000000 00001034 1 // blt x3,x1,+16
2 2 0011e863 00 00000000 00001038 0 // bltu x3,x1,+16
2 2 0032d463 00 00000000 0000103c 0 // bge x5,x3,+8
2 2 0051f463 00 00000000 00001044 1 // bgeu x3,x5,+8
2 2 fe125ce3 00 00000000 0000103c 1 // bge x4,x1,-8
2 2 0030c863 00 00000000 00001040 0 // blt x1,x3,+16
2 2 fe50ece3 00 00000000 00001038 1 // bltu x1,x5,-8
2 2 0050f863 00 00000000 0000103c 0 // bgeu x1,x5,+16
2 2 0020a863 00 00000000 00001040 0 // funct3 010 with equal operands
2 2 0020b863 00 00000000 00001044 0 // funct3 011
3 1 00000000 08 00001048 00001044 0
3 1 00000000 0a 00001078 00001044 0
3 2 020000ef 00 00000000 00001064 1 // jal x1,+32
3 2 00808863 00 00000000 00001074 1 // beq x1,x8,+16
3 2 ff1ff4ef 00 00000000 00001064 1 // jal x9,-16
3 2 00a48463 00 00000000 0000106c 1 // beq x9,x10,+8
4 1 00000000 0b 00002001 0000106c 0
4 1 00000000 0d 00001070 0000106c 0
4 2 00458667 00 00000000 00002004 1 // jalr x12,4(x11) with odd sum
4 2 00d60863 00 00000000 00002014 1 // beq x12,x13,+16
4 2 fff58067 00 00000000 00002000 1 // jalr x0,-1(x11)
4 2 0080006f 00 00000000 00002008 1 // jal x0,+8
4 2 00e00463 00 00000000 00002010 1 // beq x0,x14,+8
5 0 00000000 00 00000000 00002010 0
5 0 020000ef 00 00000000 00002010 0 // jal on the bus without strobe
5 0 00000000 00 00000000 00002010 0
5 2 00100293 00 00000000 00002014 0
5 2 00100293 00 00000000 00002018 0
5 0 00000000 00 00000000 00002018 0
5 2 00808863 00 00000000 00002028 1 // beq x1,x8,+16
5 0 00000000 00 00000000 00002028 0
5 2 fe808ce3 00 00000000 00002020 1 // beq x1,x8,-8
5 2 fe808ce3 00 00000000 00002018 1
5 0 00000000 00 00000000 00002018 0
6 1 00000000 10 0000201c 00002018 0
6 3 010007ef 0f deadbeef 00002028 1 // jal x15,+16 with external write to x15
6 2 01078463 00 00000000 00002030 1 // beq x15,x16,+8
6 0 00000000 00 00000000 00002030 0
0 f 00000000 00 00000000 00000000 0 // end

// ==== tb.f ====
source/rv_pkg.sv
source/instruction_decoder.sv
source/register_file.sv
source/jump_branch_unit.sv
source/fetch_unit.sv
source/branch_core.sv
sim/tb_branch_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the branch_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_branch_core -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_branch_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
